/* project.f */
+incdir+tb
common/shabal_pkg.sv
common/round_if.sv
common/perm_if.sv
rtl/round_ctrl.sv
rtl/msg_ring.sv
state/state_a.sv
state/state_bc.sv
state/perm_step.sv
rtl/shabal_core.sv
tb/tb_shabal.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_shabal
FILELIST  = project.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } /^Test OK$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)

/* tb/shabal_model.svh */
// Shabal-256 reference model
// Behavioural compression function with its own A, B, C and W, plus the
// Fibonacci LFSR that supplies random message words
`ifndef SHABAL_MODEL_SVH
`define SHABAL_MODEL_SVH

word_t       ref_a [A_WORDS];
word_t       ref_b [BC_WORDS];
word_t       ref_c [BC_WORDS];
logic [63:0] ref_w;

function automatic word_t rot_left(input word_t x, input int n);
	return word_t'({x, x} >> (32 - n));
endfunction

task automatic load_iv();
	ref_a = A_IV;
	ref_b = B_IV;
	ref_c = C_IV;
	ref_w = W_INIT;
endtask

task automatic compress_block(input word_t msg [BC_WORDS]);
	word_t swap;
	int    i;
	int    ai;
	for (int k = 0; k < BC_WORDS; k++) begin
		ref_b[k] = rot_left(ref_b[k] + msg[k], 17);
	end
	ref_a[0] = ref_a[0] ^ ref_w[31:0];
	ref_a[1] = ref_a[1] ^ ref_w[63:32];
	// Three passes of sixteen steps
	for (int k = 0; k < 48; k++) begin
		i  = k % BC_WORDS;
		ai = k % A_WORDS;
		ref_a[ai] = ((ref_a[ai] ^ (rot_left(ref_a[(k + 11) % A_WORDS], 15) * 32'd5)
			^ ref_c[(24 - i) % BC_WORDS]) * 32'd3) ^ ref_b[(i + 13) % BC_WORDS]
			^ (ref_b[(i + 9) % BC_WORDS] & ~ref_b[(i + 6) % BC_WORDS]) ^ msg[i];
		ref_b[i] = ~(rot_left(ref_b[i], 1) ^ ref_a[ai]);
	end
	for (int j = 0; j < 36; j++) begin
		ref_a[j % A_WORDS] = ref_a[j % A_WORDS] + ref_c[(j + 3) % BC_WORDS];
	end
	for (int k = 0; k < BC_WORDS; k++) begin
		swap     = ref_b[k];
		ref_b[k] = ref_c[k] - msg[k];
		ref_c[k] = swap;
	end
	ref_w = ref_w + 64'd1;
endtask

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic draw_word(inout logic [31:0] state, output word_t w);
	w = '0;
	for (int n = 0; n < 32; n++) begin
		state = lfsr_step(state);
		w     = {w[30:0], state[0]};
	end
endtask

`endif

/* tb/tb_shabal.sv */
`timescale 1ns/1ns
`default_nettype none
// Testbench for the Shabal-256 compression core
// Applies a table of blocks and checks busy timing and the chaining state

module tb_shabal;
	import shabal_pkg::*;

	`include "shabal_model.svh"

	localparam int CLK_PERIOD = 100;
	localparam int N_ROWS     = 6;
	localparam int BUSY_HIGH  = 47;
	localparam int BUSY_LIMIT = 100;

	logic  clk;
	logic  rst_n;
	logic  init;
	logic  en;
	word_t data;
	logic  busy;
	word_t hash_out [8];

	// Stimulus table with one row per block
	logic        row_init  [N_ROWS];
	logic [15:0] row_gaps  [N_ROWS];
	logic        row_hold  [N_ROWS];
	word_t       row_words [N_ROWS][BC_WORDS];
	word_t       row_exp   [N_ROWS][8];

	logic [31:0] lfsr_q;
	int          wd_cycles;
	logic        table_ready;
	int          pass_count;
	int          fail_count;

	shabal_core UUT (
		.clk   (clk),
		.rst_n (rst_n),
		.init  (init),
		.en    (en),
		.data  (data),
		.busy  (busy),
		.hash0 (hash_out[0]),
		.hash1 (hash_out[1]),
		.hash2 (hash_out[2]),
		.hash3 (hash_out[3]),
		.hash4 (hash_out[4]),
		.hash5 (hash_out[5]),
		.hash6 (hash_out[6]),
		.hash7 (hash_out[7])
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Table and expected values

	task automatic build_table();
		word_t blk [BC_WORDS];
		lfsr_q    = 32'h2170;
		row_init  = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
		row_gaps  = '{16'h0000, 16'h0000, 16'h8421, 16'h0000, 16'h0000, 16'hA5A5};
		row_hold  = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};
		wd_cycles = 20;
		load_iv();
		for (int r = 0; r < N_ROWS; r++) begin
			for (int k = 0; k < BC_WORDS; k++) begin
				case (r)
					0, 4: blk[k] = '0;
					5: blk[k] = word_t'(k) * 32'h0101_0101;
					default: draw_word(lfsr_q, blk[k]);
				endcase
			end
			if (row_init[r])
				load_iv();
			compress_block(blk);
			row_words[r] = blk;
			for (int k = 0; k < 8; k++) begin
				row_exp[r][k] = ref_c[8 + k];
			end
			wd_cycles += 2 * (BC_WORDS + $countones(row_gaps[r]) + 48 + 2);
		end
		table_ready = 1'b1;
	endtask

	task automatic report_test(input string name, input int errors);
		if (errors == 0) begin
			$display("%s: passed", name);
			pass_count++;
		end else begin
			$display("%s: failed with %0d errors", name, errors);
			fail_count++;
		end
	endtask

	task automatic check_reset_state();
		int errors;
		errors = 0;
		if (busy !== 1'b0) begin
			$display("Error at %0t: busy is not low after reset", $time);
			errors++;
		end
		for (int k = 0; k < 8; k++) begin
			if (hash_out[k] !== C_IV[8 + k]) begin
				$display("Mismatch at %0t: hash%0d after reset is %h, expected %h",
					$time, k, hash_out[k], C_IV[8 + k]);
				errors++;
			end
		end
		report_test("reset state", errors);
	endtask

	task automatic run_row(input int r);
		int cycles;
		int errors;
		errors = 0;
		if (row_init[r]) begin
			@(negedge clk);
			init = 1'b1;
			@(negedge clk);
			init = 1'b0;
		end
		for (int k = 0; k < BC_WORDS; k++) begin
			if (row_gaps[r][k]) begin
				@(negedge clk);
				en   = 1'b0;
				data = ~row_words[r][k];
			end
			@(negedge clk);
			en   = 1'b1;
			data = row_words[r][k];
		end
		// The sixteenth word goes in on this edge and junk follows while busy
		@(negedge clk);
		en     = row_hold[r];
		data   = 32'hFFFF_0000;
		cycles = 0;
		while (busy && cycles < BUSY_LIMIT) begin
			cycles++;
			@(negedge clk);
		end
		en = 1'b0;
		if (busy) begin
			$display("Error at %0t: busy did not fall in block %0d", $time, r);
			errors++;
		end else if (cycles != BUSY_HIGH) begin
			$display("Mismatch at %0t: block %0d busy high for %0d cycles, expected %0d",
				$time, r, cycles, BUSY_HIGH);
			errors++;
		end
		for (int k = 0; k < 8; k++) begin
			if (hash_out[k] !== row_exp[r][k]) begin
				$display("Mismatch at %0t: block %0d hash%0d is %h, expected %h",
					$time, r, k, hash_out[k], row_exp[r][k]);
				errors++;
			end
		end
		report_test($sformatf("block %0d", r), errors);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog

	initial begin
		rst_n       = 1'b0;
		init        = 1'b0;
		en          = 1'b0;
		data        = '0;
		table_ready = 1'b0;
		pass_count  = 0;
		fail_count  = 0;
		build_table();
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_reset_state();
		for (int r = 0; r < N_ROWS; r++) begin
			run_row(r);
		end
		$display("%0d tests run, %0d passed, %0d failed",
			pass_count + fail_count, pass_count, fail_count);
		if (fail_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial begin
		wait (table_ready);
		#(wd_cycles * CLK_PERIOD);
		$display("Error: watchdog expired after %0d cycles, the run did not finish", wd_cycles);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/shabal_core.sv */
`timescale 1ns/1ns
`default_nettype none
// Shabal-256 serial compression core
// Takes one 32-bit message word per clock and keeps the chaining state.
// hash0..hash7 show C8..C15 once busy drops after a block.

module shabal_core (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    init,
	input  wire                    en,
	input  wire shabal_pkg::word_t data,
	output logic                   busy,
	output shabal_pkg::word_t      hash0,
	output shabal_pkg::word_t      hash1,
	output shabal_pkg::word_t      hash2,
	output shabal_pkg::word_t      hash3,
	output shabal_pkg::word_t      hash4,
	output shabal_pkg::word_t      hash5,
	output shabal_pkg::word_t      hash6,
	output shabal_pkg::word_t      hash7
);
	import shabal_pkg::*;

	word_t m0_word;
	word_t m_sub [BC_WORDS];
	word_t c_words [BC_WORDS];

	round_if rnd_bus ();
	perm_if  perm_bus ();

	round_ctrl u_round_ctrl (
		.clk   (clk),
		.rst_n (rst_n),
		.init  (init),
		.en    (en),
		.data  (data),
		.busy  (busy),
		.rnd   (rnd_bus.ctrl)
	);

	msg_ring u_msg_ring (.clk(clk), .rst_n(rst_n), .rnd(rnd_bus.dp), .m0(m0_word), .m_sub(m_sub));

	state_a u_state_a (
		.clk     (clk),
		.rst_n   (rst_n),
		.rnd     (rnd_bus.dp),
		.perm    (perm_bus.regs),
		.c_words (c_words)
	);

	state_bc u_state_bc (
		.clk     (clk),
		.rst_n   (rst_n),
		.rnd     (rnd_bus.dp),
		.perm    (perm_bus.regs),
		.m_sub   (m_sub),
		.c_words (c_words)
	);

	perm_step u_perm_step (.perm(perm_bus.step));

	assign perm_bus.m0 = m0_word;

	assign hash0 = c_words[8];
	assign hash1 = c_words[9];
	assign hash2 = c_words[10];
	assign hash3 = c_words[11];
	assign hash4 = c_words[12];
	assign hash5 = c_words[13];
	assign hash6 = c_words[14];
	assign hash7 = c_words[15];

endmodule

`default_nettype wire

/* state/perm_step.sv */
`timescale 1ns/1ns
`default_nettype none
// One step of the Shabal keyed permutation, purely combinational

module perm_step (
	perm_if.step perm
);
	import shabal_pkg::*;

	word_t a_rot;
	word_t v_term;
	word_t u_in;
	word_t a_new;

	// V multiplies by 5, U by 3
	assign a_rot  = rotl(perm.a11, ROT_A);
	assign v_term = (a_rot << 2) + a_rot;
	assign u_in   = perm.a0 ^ v_term ^ perm.c8;

	assign a_new = ((u_in << 1) + u_in) ^ perm.b13 ^ (perm.b9 & ~perm.b6) ^ perm.m0;

	// B[i] becomes NOT((B[i] <<< 1) XOR new A)
	assign perm.new_a = a_new;
	assign perm.new_b = ~(rotl(perm.b0, 1) ^ a_new);

endmodule

`default_nettype wire

/* state/state_bc.sv */
`timescale 1ns/1ns
`default_nettype none
// Shabal B and C state
// B is a sixteen-word ring that absorbs the message and takes the step
// results. C rotates along with A during the steps. At the close round
// B gets C - M and C gets the old B.

module state_bc (
	input  wire                    clk,
	input  wire                    rst_n,
	round_if.dp                    rnd,
	perm_if.regs                   perm,
	input  wire shabal_pkg::word_t m_sub [shabal_pkg::BC_WORDS],
	output shabal_pkg::word_t      c_words [shabal_pkg::BC_WORDS]
);
	import shabal_pkg::*;

	// Ring register k holds B[k+2] whenever a block starts
	localparam int B_OFS     = 2;
	localparam int B_IN_SLOT = 13;

	word_t b_q [BC_WORDS];
	word_t c_q [BC_WORDS];
	word_t b_in;

	// Message add and rotate on the word that is about to leave slot 14
	assign b_in = rotl(b_q[B_IN_SLOT + 1] + rnd.data_word, ROT_B);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < BC_WORDS; i++) begin
				b_q[i] <= B_IV[(i + B_OFS) % BC_WORDS];
			end
		end else if (rnd.init) begin
			for (int i = 0; i < BC_WORDS; i++) begin
				b_q[i] <= B_IV[(i + B_OFS) % BC_WORDS];
			end
		end else if (rnd.advance) begin
			if (rnd.shift_bm) begin
				for (int i = 0; i < BC_WORDS - 1; i++) begin
					b_q[i] <= b_q[i + 1];
				end
				b_q[BC_WORDS - 1] <= rnd.permute_b ? b_q[0] : perm.new_b;
				if (rnd.absorb) begin
					b_q[B_IN_SLOT] <= b_in;
				end
			end else if (rnd.close_block) begin
				for (int i = 0; i < BC_WORDS; i++) begin
					b_q[i] <= c_q[(i + B_OFS) % BC_WORDS] - m_sub[(i + B_OFS) % BC_WORDS];
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			c_q <= C_IV;
		end else if (rnd.init) begin
			c_q <= C_IV;
		end else if (rnd.advance) begin
			if (rnd.shift_step) begin
				c_q[0] <= c_q[BC_WORDS - 1];
				for (int i = 1; i < BC_WORDS; i++) begin
					c_q[i] <= c_q[i - 1];
				end
			end else if (rnd.close_block) begin
				c_q <= b_q;
			end
		end
	end

	assign perm.b0  = b_q[0];
	assign perm.b6  = b_q[6];
	assign perm.b9  = b_q[9];
	assign perm.b13 = b_q[13];
	assign perm.c8  = c_q[8];
	assign c_words  = c_q;

endmodule

`default_nettype wire

/* state/state_a.sv */
`timescale 1ns/1ns
`default_nettype none
// Shabal A state
// Twelve-word shift register. W goes into A0/A1 at round 0, the steps feed
// the tail, and the C columns are added when the block closes.

module state_a (
	input  wire                    clk,
	input  wire                    rst_n,
	round_if.dp                    rnd,
	perm_if.regs                   perm,
	input  wire shabal_pkg::word_t c_words [shabal_pkg::BC_WORDS]
);
	import shabal_pkg::*;

	word_t a_q [A_WORDS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			a_q <= A_IV;
		end else if (rnd.init) begin
			a_q <= A_IV;
		end else if (rnd.inject_w) begin
			a_q[0] <= a_q[0] ^ rnd.w_lo;
			a_q[1] <= a_q[1] ^ rnd.w_hi;
		end else if (rnd.shift_step) begin
			for (int i = 0; i < A_WORDS - 1; i++) begin
				a_q[i] <= a_q[i + 1];
			end
			a_q[A_WORDS - 1] <= perm.new_a;
		end else if (rnd.close_block) begin
			// A[i] += C[i+3] + C[i+15] + C[i+11]
			for (int i = 0; i < A_WORDS; i++) begin
				a_q[i] <= a_q[i] + c_words[(i + 3) % BC_WORDS]
					+ c_words[(i + 15) % BC_WORDS] + c_words[(i + 11) % BC_WORDS];
			end
		end
	end

	assign perm.a0  = a_q[0];
	assign perm.a11 = a_q[A_WORDS - 1];

	a_w_not_in_step: assert property (@(posedge clk) disable iff (!rst_n)
		!(rnd.inject_w && rnd.shift_step));

endmodule

`default_nettype wire

/* rtl/msg_ring.sv */
`timescale 1ns/1ns
`default_nettype none
// Message ring
// Sixteen words that take the incoming message and rotate through the steps

module msg_ring (
	input  wire               clk,
	input  wire               rst_n,
	round_if.dp               rnd,
	output shabal_pkg::word_t m0,
	output shabal_pkg::word_t m_sub [shabal_pkg::BC_WORDS]
);
	import shabal_pkg::*;

	// New words enter here so that M0 reaches slot 0 when the steps begin
	localparam int INSERT_SLOT = 13;

	word_t m_q [BC_WORDS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < BC_WORDS; i++) begin
				m_q[i] <= '0;
			end
		end else if (rnd.shift_bm) begin
			for (int i = 0; i < BC_WORDS; i++) begin
				m_q[i] <= m_q[(i + 1) % BC_WORDS];
			end
			if (rnd.absorb) begin
				m_q[INSERT_SLOT] <= rnd.data_word;
			end
		end
	end

	// The ring is back in natural order at the close round
	assign m0    = m_q[0];
	assign m_sub = m_q;

endmodule

`default_nettype wire

/* rtl/round_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none
// Round sequencer
// Counts the rounds of a block, accepts the sixteen message words,
// runs the step and close rounds on its own and keeps the block counter W.

module round_ctrl (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    init,
	input  wire                    en,
	input  wire shabal_pkg::word_t data,
	output logic                   busy,
	round_if.ctrl                  rnd
);
	import shabal_pkg::*;

	localparam int BUSY_CYCLES = ROUND_LAST - LOAD_LAST;

	round_t      round;
	logic [63:0] w_cnt;
	logic        accept;
	logic        advance;
	logic        restart;

	// Once the last word is in, the remaining rounds need no input
	assign busy    = (round > LOAD_LAST);
	assign restart = init && !busy;
	assign accept  = en && !busy && !init;
	assign advance = accept || busy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			round <= '0;
		end else if (restart) begin
			round <= '0;
		end else if (advance) begin
			if (round == ROUND_LAST)
				round <= '0;
			else
				round <= round + 6'd1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			w_cnt <= W_INIT;
		end else if (restart) begin
			w_cnt <= W_INIT;
		end else if (rnd.close_block) begin
			w_cnt <= w_cnt + 64'd1;
		end
	end

	assign rnd.advance     = advance;
	assign rnd.init        = restart;
	assign rnd.absorb      = accept;
	assign rnd.inject_w    = advance && (round == '0);
	assign rnd.shift_step  = advance && (round >= STEP_FIRST) && (round <= STEP_LAST);
	assign rnd.shift_bm    = advance && (round <= STEP_LAST);
	assign rnd.permute_b   = advance && (round < STEP_FIRST);
	assign rnd.close_block = advance && (round == ROUND_LAST);
	assign rnd.w_lo        = w_cnt[31:0];
	assign rnd.w_hi        = w_cnt[63:32];
	assign rnd.data_word   = data;

	a_round_range: assert property (@(posedge clk) disable iff (!rst_n)
		round <= ROUND_LAST);

	// After the last word no word gets in until the block has closed
	a_no_accept_busy: assert property (@(posedge clk) disable iff (!rst_n)
		rnd.absorb && (round == LOAD_LAST) |=> !rnd.absorb [*BUSY_CYCLES] ##1 !busy);

endmodule

`default_nettype wire

/* common/perm_if.sv */
`timescale 1ns/1ns
`default_nettype none
// Permutation taps from the state registers and the step results back

interface perm_if;
	import shabal_pkg::*;

	word_t a0;
	word_t a11;
	word_t b0;
	word_t b6;
	word_t b9;
	word_t b13;
	word_t c8;
	word_t m0;
	word_t new_a;
	word_t new_b;

	modport regs (output a0, a11, b0, b6, b9, b13, c8, m0, input new_a, new_b);
	modport step (input a0, a11, b0, b6, b9, b13, c8, m0, output new_a, new_b);

endinterface

`default_nettype wire

/* common/round_if.sv */
`timescale 1ns/1ns
`default_nettype none
// Round strobes and block counter from the sequencer to the datapath

interface round_if;
	import shabal_pkg::*;

	logic  advance;
	logic  init;
	logic  absorb;
	logic  inject_w;
	logic  shift_step;
	logic  shift_bm;
	logic  permute_b;
	logic  close_block;
	word_t w_lo;
	word_t w_hi;
	word_t data_word;

	modport ctrl (output advance, init, absorb, inject_w, shift_step, shift_bm, permute_b,
		close_block, w_lo, w_hi, data_word);
	modport dp (input advance, init, absorb, inject_w, shift_step, shift_bm, permute_b,
		close_block, w_lo, w_hi, data_word);

endinterface

`default_nettype wire

/* common/shabal_pkg.sv */
`default_nettype none
// Shabal-256 shared definitions
// Word type, state sizes, round schedule and the initial chaining values

package shabal_pkg;

	typedef logic [31:0] word_t;
	typedef logic [5:0]  round_t;

	localparam int A_WORDS  = 12;
	localparam int BC_WORDS = 16;

	// One block runs rounds 0..62, words load in 0..15 and steps run in 14..61
	localparam round_t ROUND_LAST = 6'd62;
	localparam round_t STEP_FIRST = 6'd14;
	localparam round_t STEP_LAST  = 6'd61;
	localparam round_t LOAD_LAST  = 6'd15;

	localparam int ROT_B = 17;
	localparam int ROT_A = 15;

	localparam logic [63:0] W_INIT = 64'd1;

	localparam word_t A_IV [A_WORDS] = '{
		32'h52F84552, 32'hE54B7999, 32'h2D8EE3EC, 32'hB9645191,
		32'hE0078B86, 32'hBB7C44C9, 32'hD2B5C1CA, 32'hB0D2EB8C,
		32'h14CE5A45, 32'h22AF50DC, 32'hEFFDBC6B, 32'hEB21B74A
	};

	localparam word_t B_IV [BC_WORDS] = '{
		32'hB555C6EE, 32'h3E710596, 32'hA72A652F, 32'h9301515F,
		32'hDA28C1FA, 32'h696FD868, 32'h9CB6BF72, 32'h0AFE4002,
		32'hA6E03615, 32'h5138C1D4, 32'hBE216306, 32'hB38B8890,
		32'h3EA8B96B, 32'h3299ACE4, 32'h30924DD4, 32'h55CB34A5
	};

	localparam word_t C_IV [BC_WORDS] = '{
		32'hB405F031, 32'hC4233EBA, 32'hB3733979, 32'hC0DD9D55,
		32'hC51C28AE, 32'hA327B8E1, 32'h56C56167, 32'hED614433,
		32'h88B59D60, 32'h60E2CEBA, 32'h758B4B8B, 32'h83E82A7F,
		32'hBC968828, 32'hE6E00BF7, 32'hBA839E55, 32'h9B491C60
	};

	// Left rotation of a word
	function automatic word_t rotl(input word_t x, input int unsigned n);
		return (x << n) | (x >> (32 - n));
	endfunction

endpackage

`default_nettype wire
